// ==== Makefile ====
# Verilator flow for the delay line bank

TOP = tb_delay_bank
OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f project.f --top-module $(TOP)

run: build
	./$(OBJ)/V$(TOP) | tee sim.log
	@grep -q 'All tests passed!' sim.log || (echo "simulation failed, see sim.log"; exit 1)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log

// ==== delay_bank_props.sv ====
// concurrent checks on the delay bank
// bound to delay_bank_top, covers reset values, held strobes and readback stability

`default_nettype none

module delay_bank_props (
    input wire logic                                                clk,
    input wire logic                                                reset,
    input wire logic [dly_pkg::SEL_WIDTH-1:0]                       sel_dly_i,
    input wire logic                                                dly_ld_i,
    input wire logic                                                dly_adj_i,
    input wire logic [dly_pkg::NUM_DLY-1:0][dly_pkg::TAP_WIDTH-1:0] tap_bus_i,
    input wire logic [dly_pkg::NUM_DLY-1:0]                         data_o,
    input wire logic [dly_pkg::TAP_WIDTH-1:0]                       tap_val_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // outputs are clear one cycle after a reset edge
    property p_reset_clears;
        @(posedge clk) reset |=> (tap_val_o == '0 && data_o == '0);
    endproperty

    // strobe held high with no other rise, no line tap moves
    property p_held_adjust;
        @(posedge clk) disable iff (reset)
            ($past(dly_adj_i, 2) && $past(dly_adj_i, 3) && !$past(dly_ld_i, 2))
                |-> $stable(tap_bus_i);
    endproperty

    property p_held_load;
        @(posedge clk) disable iff (reset)
            ($past(dly_ld_i, 2) && $past(dly_ld_i, 3) && !$past(dly_adj_i, 2))
                |-> $stable(tap_bus_i);
    endproperty

    // a readback change needs a strobe rise or a new select
    property p_readback_cause;
        @(posedge clk) disable iff (reset)
            $changed(tap_val_o) |->
                (($past(dly_ld_i, 3) && !$past(dly_ld_i, 4)) ||
                 ($past(dly_adj_i, 3) && !$past(dly_adj_i, 4)) ||
                 $past(sel_dly_i, 1) != $past(sel_dly_i, 2));
    endproperty

    a_reset_clears:   assert property (p_reset_clears) else $error("outputs not clear after reset");
    a_held_adjust:    assert property (p_held_adjust) else $error("held adjust moved the tap again");
    a_held_load:      assert property (p_held_load) else $error("held load moved the tap again");
    a_readback_cause: assert property (p_readback_cause) else $error("readback moved without cause");

endmodule

bind delay_bank_top delay_bank_props u_props (
    .clk       (clk),
    .reset     (reset),
    .sel_dly_i (sel_dly_i),
    .dly_ld_i  (dly_ld_i),
    .dly_adj_i (dly_adj_i),
    .tap_bus_i (tap_bus),
    .data_o    (data_o),
    .tap_val_o (tap_val_o)
);

`default_nettype wire

// ==== delay_bank_top.sv ====
// top level of the four-line delay bank
// one shared strobe port controls the line picked by sel_dly_i,
// each line delays its own data bit by its tap plus one cycle

`default_nettype none

module delay_bank_top (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [dly_pkg::SEL_WIDTH-1:0] sel_dly_i,
    input  wire logic                          dly_ld_i,
    input  wire logic                          dly_adj_i,
    input  wire logic                          dly_incdec_i,
    input  wire logic [dly_pkg::TAP_WIDTH-1:0] tap_load_i,
    input  wire logic [dly_pkg::NUM_DLY-1:0]   data_i,
    output logic      [dly_pkg::NUM_DLY-1:0]   data_o,
    output logic      [dly_pkg::TAP_WIDTH-1:0] tap_val_o
);

    import dly_pkg::*;

    logic [NUM_DLY-1:0][TAP_WIDTH-1:0] tap_bus;   // taps of all lines
    logic [NUM_DLY-1:0]                line_load;
    logic [NUM_DLY-1:0]                line_adj;
    logic                              line_inc;
    logic [TAP_WIDTH-1:0]              line_val;

    delay_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .sel_dly_i    (sel_dly_i),
        .dly_ld_i     (dly_ld_i),
        .dly_adj_i    (dly_adj_i),
        .dly_incdec_i (dly_incdec_i),
        .tap_load_i   (tap_load_i),
        .tap_bus_i    (tap_bus),
        .line_load_o  (line_load),
        .line_adj_o   (line_adj),
        .inc_o        (line_inc),
        .load_val_o   (line_val),
        .tap_val_o    (tap_val_o)
    );

    // direction and load value are shared, the pulses are per line
    for (genvar k = 0; k < NUM_DLY; k++) begin : g_line
        delay_line u_line (
            .clk        (clk),
            .reset      (reset),
            .data_i     (data_i[k]),
            .load_i     (line_load[k]),
            .adj_i      (line_adj[k]),
            .inc_i      (line_inc),
            .load_val_i (line_val),
            .tap_o      (tap_bus[k]),
            .data_o     (data_o[k])
        );
    end

endmodule

`default_nettype wire

// ==== delay_ctrl.sv ====
// control unit of the delay line bank
// turns the load and adjust strobe levels into one-cycle command pulses
// for the selected line and registers the tap readback of that line

`default_nettype none

module delay_ctrl (
    input  wire logic                                                clk,
    input  wire logic                                                reset,
    input  wire logic [dly_pkg::SEL_WIDTH-1:0]                       sel_dly_i,
    input  wire logic                                                dly_ld_i,
    input  wire logic                                                dly_adj_i,
    input  wire logic                                                dly_incdec_i,
    input  wire logic [dly_pkg::TAP_WIDTH-1:0]                       tap_load_i,
    input  wire logic [dly_pkg::NUM_DLY-1:0][dly_pkg::TAP_WIDTH-1:0] tap_bus_i,
    output logic      [dly_pkg::NUM_DLY-1:0]                         line_load_o,
    output logic      [dly_pkg::NUM_DLY-1:0]                         line_adj_o,
    output logic                                                     inc_o,
    output logic      [dly_pkg::TAP_WIDTH-1:0]                       load_val_o,
    output logic      [dly_pkg::TAP_WIDTH-1:0]                       tap_val_o
);

    import dly_pkg::*;

    logic                 ld_q;     // strobe levels from the previous edge
    logic                 adj_q;
    logic                 ld_rise;
    logic                 adj_rise;
    dly_cmd_e             cmd_q;
    logic [SEL_WIDTH-1:0] sel_q;    // line captured with the command
    logic                 inc_q;
    logic [TAP_WIDTH-1:0] val_q;
    logic [TAP_WIDTH-1:0] tap_val_q;

    // ************************************************************************
    // strobe edge detection and command register
    // ************************************************************************

    // high now, low on the edge before
    assign ld_rise  = dly_ld_i & ~ld_q;
    assign adj_rise = dly_adj_i & ~adj_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_q  <= 1'b0;
            adj_q <= 1'b0;
            cmd_q <= CMD_IDLE;
        end else begin
            ld_q  <= dly_ld_i;
            adj_q <= dly_adj_i;
            if (ld_rise) begin
                cmd_q <= CMD_LOAD;       // load wins over a same-edge adjust
            end else if (adj_rise) begin
                cmd_q <= CMD_ADJUST;
            end else begin
                cmd_q <= CMD_IDLE;       // back to idle after one cycle
            end
        end
    end

    // select, direction and load value travel with the command
    always_ff @(posedge clk) begin
        if (ld_rise || adj_rise) begin
            sel_q <= sel_dly_i;
            inc_q <= dly_incdec_i;
            val_q <= tap_load_i;
        end
    end

    // ************************************************************************
    // command routing to the lines
    // ************************************************************************

    always_comb begin
        line_load_o = '0;
        line_adj_o  = '0;
        case (cmd_q)
            CMD_LOAD:   line_load_o[sel_q] = 1'b1;
            CMD_ADJUST: line_adj_o[sel_q]  = 1'b1;
            default:    line_load_o        = '0;
        endcase
    end

    assign inc_o      = inc_q;      // shared by all lines
    assign load_val_o = val_q;

    // ************************************************************************
    // tap readback
    // ************************************************************************

    // follows sel_dly_i with one cycle of latency
    always_ff @(posedge clk) begin
        if (reset) begin
            tap_val_q <= '0;
        end else begin
            tap_val_q <= tap_bus_i[sel_dly_i];
        end
    end

    assign tap_val_o = tap_val_q;

endmodule

`default_nettype wire

// ==== delay_line.sv ====
// one programmable delay line of the bank
// the tap register is written by load pulses and stepped by adjust pulses,
// the serial input leaves tap + 1 cycles later

`default_nettype none

module delay_line (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          data_i,
    input  wire logic                          load_i,
    input  wire logic                          adj_i,
    input  wire logic                          inc_i,
    input  wire logic [dly_pkg::TAP_WIDTH-1:0] load_val_i,
    output logic      [dly_pkg::TAP_WIDTH-1:0] tap_o,
    output logic                               data_o
);

    import dly_pkg::*;

    logic [TAP_WIDTH-1:0] tap_q;
    logic [TAP_WIDTH-1:0] tap_next;
    logic [DEPTH-1:0]     shift_q;   // stage 0 holds the newest sample
    logic                 data_q;

    // ************************************************************************
    // tap register
    // ************************************************************************

    always_comb begin
        tap_next = tap_q;
        if (load_i) begin
            tap_next = load_val_i;
        end else if (adj_i) begin
            if (inc_i) begin
                if (tap_q != MAX_TAP) begin
                    tap_next = tap_q + 1'b1;
                end
            end else begin
                if (tap_q != '0) begin
                    tap_next = tap_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tap_q <= RESET_TAP;
        end else begin
            tap_q <= tap_next;
        end
    end

    assign tap_o = tap_q;

    // ************************************************************************
    // data delay
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '0;
            data_q  <= 1'b0;
        end else begin
            shift_q <= {shift_q[DEPTH-2:0], data_i};
            data_q  <= shift_q[tap_q];      // output flop adds the extra cycle
        end
    end

    assign data_o = data_q;

endmodule

`default_nettype wire

// ==== dly_pkg.sv ====
// shared sizes, tap limits and the command type for the delay line bank
// imported by the control unit, the delay lines and the top level

`default_nettype none

package dly_pkg;

    // ************************************************************************
    // bank geometry
    // ************************************************************************
    localparam int unsigned NUM_DLY   = 4;   // delay lines in the bank
    localparam int unsigned SEL_WIDTH = 2;   // line select width
    localparam int unsigned TAP_WIDTH = 6;   // tap value width

    // tap range, the adjust saturates at both ends
    localparam logic [TAP_WIDTH-1:0] MAX_TAP   = 6'd63;
    localparam logic [TAP_WIDTH-1:0] RESET_TAP = 6'd0;

    // one shift stage per tap position
    localparam int unsigned DEPTH = int'(MAX_TAP) + 1;

    // registered command of the control unit
    typedef enum logic [1:0] {
        CMD_IDLE   = 2'd0,
        CMD_LOAD   = 2'd1,
        CMD_ADJUST = 2'd2
    } dly_cmd_e;

endpackage

`default_nettype wire

// ==== project.f ====
dly_pkg.sv
delay_ctrl.sv
delay_line.sv
delay_bank_top.sv
delay_bank_props.sv
tb_delay_bank.sv

// ==== tb_delay_bank.sv ====
// testbench for the four-line delay bank
// drives loads, adjusts and random data, predicts taps and delayed bits
// from a reference model and ends with a summary of checks and errors

`default_nettype none

module tb_delay_bank;
    timeunit 1ns;
    timeprecision 100ps;

    import dly_pkg::*;

    localparam int HIST_BITS = 10;
    localparam int HIST_LEN  = 1 << HIST_BITS;
    localparam int TIMEOUT   = 10;          // cycles allowed for a readback

    logic                 clk;
    logic                 reset;
    logic [SEL_WIDTH-1:0] sel_dly_i;
    logic                 dly_ld_i;
    logic                 dly_adj_i;
    logic                 dly_incdec_i;
    logic [TAP_WIDTH-1:0] tap_load_i;
    logic [NUM_DLY-1:0]   data_i;
    logic [NUM_DLY-1:0]   data_o;
    logic [TAP_WIDTH-1:0] tap_val_o;

    logic [TAP_WIDTH-1:0] model_tap [NUM_DLY];   // reference taps
    logic [NUM_DLY-1:0]   hist [HIST_LEN];       // data_i seen at each edge
    int                   cyc;
    int                   checks;
    int                   errors;

    delay_bank_top u_delay_bank_top (
        .clk          (clk),
        .reset        (reset),
        .sel_dly_i    (sel_dly_i),
        .dly_ld_i     (dly_ld_i),
        .dly_adj_i    (dly_adj_i),
        .dly_incdec_i (dly_incdec_i),
        .tap_load_i   (tap_load_i),
        .data_i       (data_i),
        .data_o       (data_o),
        .tap_val_o    (tap_val_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ************************************************************************
    // helpers
    // ************************************************************************

    function automatic logic [HIST_BITS-1:0] hist_idx(input int c);
        return HIST_BITS'(c);   // ring index
    endfunction

    // tap after a command, per the strobe rule
    function automatic logic [TAP_WIDTH-1:0] expected_tap(input logic [TAP_WIDTH-1:0] cur,
            input logic ld, input logic adj, input logic inc,
            input logic [TAP_WIDTH-1:0] val);
        int t;
        t = int'(cur);
        if (ld) begin
            return val;         // load wins
        end
        if (adj) begin
            t = inc ? t + 1 : t - 1;
            if (t > int'(MAX_TAP)) t = int'(MAX_TAP);
            if (t < 0) t = 0;
        end
        return TAP_WIDTH'(t);
    endfunction

    // one clock, then 5 ns so outputs are settled and inputs can change
    task automatic tick();
        @(posedge clk);
        cyc++;
        hist[hist_idx(cyc)] = data_i;
        #5;
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic read_tap(input logic [SEL_WIDTH-1:0] sel, input string name);
        sel_dly_i = sel;
        tick();
        check_value(name, int'(model_tap[sel]), int'(tap_val_o));
    endtask

    // raise the strobes for hold cycles and wait for the new tap to read back
    task automatic command(input string name, input logic [SEL_WIDTH-1:0] sel,
            input logic ld, input logic adj, input logic inc,
            input logic [TAP_WIDTH-1:0] val, input int hold);
        logic [TAP_WIDTH-1:0] old_tap;
        logic [TAP_WIDTH-1:0] new_tap;
        int                   n;
        old_tap      = model_tap[sel];
        new_tap      = expected_tap(old_tap, ld, adj, inc, val);
        sel_dly_i    = sel;
        dly_incdec_i = inc;
        tap_load_i   = val;
        dly_ld_i     = ld;
        dly_adj_i    = adj;
        n = 0;
        do begin
            tick();
            n++;
            if (n == hold) begin
                dly_ld_i  = 1'b0;
                dly_adj_i = 1'b0;
            end
            if (n <= 2) begin
                check_value({name, " before update"}, int'(old_tap), int'(tap_val_o));
            end
        end while (!(n >= 3 && tap_val_o == new_tap) && n < TIMEOUT);
        if (tap_val_o != new_tap) begin
            checks++;
            errors++;
            $display("%s: tap readback never reached the new value", name);
        end else begin
            check_value({name, " latency"}, 3, n);
        end
        model_tap[sel] = new_tap;
        while (n < hold + 1) begin      // held strobe must not act again
            tick();
            n++;
            if (n == hold) begin
                dly_ld_i  = 1'b0;
                dly_adj_i = 1'b0;
            end
            check_value({name, " held"}, int'(new_tap), int'(tap_val_o));
        end
    endtask

    // ************************************************************************
    // stimulus
    // ************************************************************************

    initial begin
        logic [TAP_WIDTH-1:0] val;
        logic                 exp_bit;
        void'($urandom(10));
        reset        = 1'b1;
        sel_dly_i    = '0;
        dly_ld_i     = 1'b0;
        dly_adj_i    = 1'b0;
        dly_incdec_i = 1'b0;
        tap_load_i   = '0;
        data_i       = '0;
        cyc          = 0;
        checks       = 0;
        errors       = 0;
        for (int k = 0; k < NUM_DLY; k++) begin
            model_tap[k] = RESET_TAP;
        end
        repeat (5) tick();
        reset = 1'b0;

        // state after reset
        for (int k = 0; k < NUM_DLY; k++) begin
            read_tap(SEL_WIDTH'(k), "reset_tap");
            check_value("reset_data", 0, int'(data_o));
        end

        // random load per line, other lines keep their taps
        for (int k = 0; k < NUM_DLY; k++) begin
            val = TAP_WIDTH'($urandom);
            command("load_line", SEL_WIDTH'(k), 1'b1, 1'b0, 1'b0, val, 1);
            for (int j = 0; j < NUM_DLY; j++) begin
                read_tap(SEL_WIDTH'(j), "load_keep");
            end
        end

        // saturation at both ends and held strobes
        command("load_62", 2'd1, 1'b1, 1'b0, 1'b0, 6'd62, 1);
        command("adjust_to_max", 2'd1, 1'b0, 1'b1, 1'b1, 6'd0, 1);
        command("sat_high", 2'd1, 1'b0, 1'b1, 1'b1, 6'd0, 1);
        command("load_1", 2'd1, 1'b1, 1'b0, 1'b0, 6'd1, 1);
        command("adjust_to_zero", 2'd1, 1'b0, 1'b1, 1'b0, 6'd0, 1);
        command("sat_low", 2'd1, 1'b0, 1'b1, 1'b0, 6'd0, 1);
        command("held_adjust", 2'd1, 1'b0, 1'b1, 1'b1, 6'd0, 4);
        command("held_load", 2'd1, 1'b1, 1'b0, 1'b0, 6'd20, 3);

        // load and adjust on the same edge
        val = TAP_WIDTH'($urandom);
        command("load_and_adjust", 2'd2, 1'b1, 1'b1, 1'b1, val, 1);
        read_tap(2'd2, "load_and_adjust_readback");

        // distinct taps, then random data through every line
        for (int k = 0; k < NUM_DLY; k++) begin
            val = TAP_WIDTH'(16 * k + int'($urandom_range(15, 0)));
            command("data_tap", SEL_WIDTH'(k), 1'b1, 1'b0, 1'b0, val, 1);
        end
        for (int i = 0; i < 150; i++) begin
            data_i = NUM_DLY'($urandom);
            tick();
            for (int k = 0; k < NUM_DLY; k++) begin
                exp_bit = hist[hist_idx(cyc - int'(model_tap[k]) - 1)][SEL_WIDTH'(k)];
                check_value("data_delay", int'(exp_bit), int'(data_o[SEL_WIDTH'(k)]));
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
